/* all.f */
+incdir+common
common/bus_pkg.sv
common/inst_pkg.sv
fetch/fetch_unit.sv
source/fetch_buffer.sv
source/dispatch_stage.sv
source/frontend_top.sv
verif/frontend_checker.sv
verif/frontend_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := frontend_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+1000
FAIL_MSG  := ERRORS FOUND
PASS_MSG  := NO ERRORS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defines.svh"

module frontend_tb
  import bus_pkg::*;
  import inst_pkg::*;
();

  // Same addresses as the checker binding
  localparam logic [`XLEN-1:0] HALT_ADDR    = 64'h0000_0000_0001_0004;
  localparam logic [`XLEN-1:0] ILLEGAL_ADDR = 64'h0000_0000_0002_0000;

  logic                                clock;
  logic                                arst_n;
  logic                                rob_ready;
  logic                                rs_ready;
  logic                                fl_ready;
  logic                                rollback_en;
  logic [`XLEN-1:0]                    rollback_pc;
  bus_cmd_t                            dmem_command;
  logic [`XLEN-1:0]                    dmem_addr;
  logic [`XLEN-1:0]                    dmem_data;
  mem_tag_t                            mem2proc_response;
  logic [`XLEN-1:0]                    mem2proc_data;
  mem_tag_t                            mem2proc_tag;
  bus_cmd_t                            proc2mem_command;
  logic [`XLEN-1:0]                    proc2mem_addr;
  logic [`XLEN-1:0]                    proc2mem_data;
  mem_tag_t                            dmem_response;
  logic [`NUM_SUPER-1:0]               disp_valid;
  logic [`NUM_SUPER-1:0][`XLEN-1:0]    disp_pc;
  logic [`NUM_SUPER-1:0][`INST_W-1:0]  disp_inst;
  logic [3:0]                          completed_insts;
  error_code_t                         error_status;
  logic                                stop_cycle;

  bit               ready_noise;
  int unsigned      cycle_no;
  int unsigned      timeouts;
  int unsigned      tests_passed;
  int unsigned      tests_failed;
  int unsigned      fails_before;
  int unsigned      timeouts_before;
  mem_tag_t         next_tag;
  mem_tag_t         pend_tags[$];
  logic [`XLEN-1:0] pend_addrs[$];
  int unsigned      pend_due[$];

  frontend_top dut_i (.*);

  always #50 clock = ~clock;

  function automatic logic [`INST_W-1:0] mem_word(input logic [`XLEN-1:0] addr);
    if (addr == HALT_ADDR)
      return `HALT_INST;
    if (addr == ILLEGAL_ADDR)
      return {6'h01, addr[27:2]};
    return {6'h10, addr[27:2]};
  endfunction

  // Memory answers once the stimulus of the cycle has settled
  always @(posedge clock) begin
    #2;
    cycle_no++;
    if (!arst_n) begin
      pend_tags.delete();
      pend_addrs.delete();
      pend_due.delete();
      next_tag          = 4'd1;
      mem2proc_response = '0;
      mem2proc_tag      = '0;
      mem2proc_data     = '0;
    end else begin
      mem2proc_tag  = '0;
      mem2proc_data = '0;
      if (pend_due.size() > 0 && pend_due[0] <= cycle_no) begin
        mem2proc_tag  = pend_tags.pop_front();
        mem2proc_data = {mem_word(pend_addrs[0] + `XLEN'd4), mem_word(pend_addrs[0])};
        void'(pend_addrs.pop_front());
        void'(pend_due.pop_front());
      end
      mem2proc_response = '0;
      if (proc2mem_command != BUS_NONE && $urandom_range(7) != 0) begin  // 1 in 8 refused
        mem2proc_response = next_tag;
        if (proc2mem_command == BUS_LOAD) begin
          pend_tags.push_back(next_tag);
          pend_addrs.push_back(proc2mem_addr);
          pend_due.push_back(cycle_no + $urandom_range(4, 1));
        end
        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
    end
  end

  // Random ready gaps go out with the rest of the cycle's stimulus
  task automatic next_cycle();
    @(posedge clock);
    #1;
    if (ready_noise) begin
      rob_ready = ($urandom_range(5) != 0);
      rs_ready  = ($urandom_range(5) != 0);
      fl_ready  = ($urandom_range(5) != 0);
    end
  endtask

  task automatic wait_dispatched(input int n, input int limit);
    int seen;
    int waited;
    seen   = 0;
    waited = 0;
    while (seen < n && waited < limit) begin
      next_cycle();
      seen   += $countones(disp_valid);
      waited += 1;
    end
    if (seen < n) begin
      $display("timeout: only %0d of %0d instructions dispatched in %0d cycles",
               seen, n, limit);
      timeouts++;
    end
  endtask

  task automatic wait_stop(input int limit);
    int waited;
    waited = 0;
    while (!stop_cycle && waited < limit) begin
      next_cycle();
      waited += 1;
    end
    if (!stop_cycle) begin
      $display("timeout: stop_cycle never rose within %0d cycles", limit);
      timeouts++;
    end
  endtask

  task automatic rollback_to(input logic [`XLEN-1:0] target);
    rollback_en = 1'b1;
    rollback_pc = target;
    next_cycle();
    rollback_en = 1'b0;
  endtask

  task automatic start_test();
    fails_before    = dut_i.checker_i.fail_count;
    timeouts_before = timeouts;
  endtask

  task automatic end_test(input string name);
    if (dut_i.checker_i.fail_count != fails_before || timeouts != timeouts_before) begin
      $display("test %s: failed", name);
      tests_failed++;
    end else begin
      $display("test %s: passed", name);
      tests_passed++;
    end
  endtask

  initial begin
    void'($urandom(32'h8396_bb17));
    clock             = 1'b0;
    arst_n            = 1'b0;
    rob_ready         = 1'b1;
    rs_ready          = 1'b1;
    fl_ready          = 1'b1;
    rollback_en       = 1'b0;
    rollback_pc       = '0;
    dmem_command      = BUS_NONE;
    dmem_addr         = '0;
    dmem_data         = '0;
    mem2proc_response = '0;
    mem2proc_data     = '0;
    mem2proc_tag      = '0;
    ready_noise       = 1'b0;
    next_tag          = 4'd1;
    repeat (2) @(posedge clock);
    #1;
    arst_n = 1'b1;

    start_test();
    ready_noise = 1'b1;
    wait_dispatched(40, 400);
    end_test("sequential fetch");

    start_test();
    ready_noise = 1'b0;
    rob_ready   = 1'b1;
    rs_ready    = 1'b1;
    fl_ready    = 1'b0;  // buffer fills, fetch must stall
    repeat (10) next_cycle();
    fl_ready  = 1'b1;
    rob_ready = 1'b0;
    repeat (5) next_cycle();
    rob_ready = 1'b1;
    wait_dispatched(16, 200);
    end_test("ready stall");

    start_test();
    ready_noise = 1'b1;
    repeat (30) begin
      case ($urandom_range(3))
        0: dmem_command = BUS_LOAD;
        1: dmem_command = BUS_STORE;
        default: dmem_command = BUS_NONE;
      endcase
      dmem_addr = {$urandom, $urandom};
      dmem_data = {$urandom, $urandom};
      next_cycle();
    end
    dmem_command = BUS_NONE;
    wait_dispatched(10, 200);
    end_test("data side sharing");

    start_test();
    rollback_to(64'h0000_0000_0000_1000);
    wait_dispatched(8, 200);
    rollback_to(64'h0000_0000_0000_2004);  // odd word, single instruction line
    wait_dispatched(8, 200);
    end_test("rollback");

    start_test();
    rollback_to(HALT_ADDR - `XLEN'd16);
    wait_stop(300);
    repeat (12) next_cycle();
    end_test("halt");

    start_test();
    ready_noise = 1'b0;
    rob_ready   = 1'b1;
    rs_ready    = 1'b1;
    fl_ready    = 1'b1;
    arst_n      = 1'b0;
    repeat (2) next_cycle();
    arst_n = 1'b1;
    rollback_to(ILLEGAL_ADDR - `XLEN'd8);
    wait_stop(300);
    repeat (12) next_cycle();
    end_test("illegal after reset");

    $display("tests: %0d passed, %0d failed, %0d assertion failures, %0d timeouts",
             tests_passed, tests_failed, dut_i.checker_i.fail_count, timeouts);
    if (tests_failed == 0 && dut_i.checker_i.fail_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/frontend_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defines.svh"

module frontend_checker
  import bus_pkg::*;
  import inst_pkg::*;
#(
  parameter logic [`XLEN-1:0] HALT_ADDR    = `XLEN'h0,
  parameter logic [`XLEN-1:0] ILLEGAL_ADDR = `XLEN'h0
) (
  input  logic                                clock,
  input  logic                                arst_n,
  input  logic                                rob_ready,
  input  logic                                rs_ready,
  input  logic                                fl_ready,
  input  logic                                rollback_en,
  input  logic [`XLEN-1:0]                    rollback_pc,
  input  bus_cmd_t                            dmem_command,
  input  logic [`XLEN-1:0]                    dmem_addr,
  input  logic [`XLEN-1:0]                    dmem_data,
  input  mem_tag_t                            mem2proc_response,
  input  bus_cmd_t                            proc2mem_command,
  input  logic [`XLEN-1:0]                    proc2mem_addr,
  input  logic [`XLEN-1:0]                    proc2mem_data,
  input  mem_tag_t                            dmem_response,
  input  logic [`NUM_SUPER-1:0]               disp_valid,
  input  logic [`NUM_SUPER-1:0][`XLEN-1:0]    disp_pc,
  input  logic [`NUM_SUPER-1:0][`INST_W-1:0]  disp_inst,
  input  logic [3:0]                          completed_insts,
  input  error_code_t                         error_status,
  input  logic                                stop_cycle
);

  int unsigned      fail_count = 0;
  logic [`XLEN-1:0] next_pc;  // PC the next dispatch must carry

  function automatic logic [`INST_W-1:0] mem_word(input logic [`XLEN-1:0] addr);
    if (addr == HALT_ADDR)
      return `HALT_INST;
    if (addr == ILLEGAL_ADDR)
      return {`ILLEGAL_OPC_LO, addr[27:2]};
    return {6'h10, addr[27:2]};
  endfunction

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n)
      next_pc <= '0;
    else if (rollback_en)
      next_pc <= rollback_pc;  // redirect wins over older dispatches
    else if (disp_valid[1])
      next_pc <= disp_pc[1] + `XLEN'd4;
    else if (disp_valid[0])
      next_pc <= disp_pc[0] + `XLEN'd4;
  end

  for (genvar i = 0; i < `NUM_SUPER; i++) begin : g_slot
    word_ok: assert property (@(posedge clock) disable iff (!arst_n)
        disp_valid[i] |-> disp_inst[i] == mem_word(disp_pc[i]))
      else begin
        fail_count = fail_count + 1;
        $error("FAILED at %0t: disp_inst[%0d] = %h, expected %h", $time, i,
               $sampled(disp_inst[i]), mem_word($sampled(disp_pc[i])));
      end

    halt_ok: assert property (@(posedge clock) disable iff (!arst_n)
        disp_valid[i] && disp_pc[i] == HALT_ADDR |-> stop_cycle &&
        error_status == HALTED_ON_HALT)
      else begin
        fail_count = fail_count + 1;
        $error("FAILED at %0t: error_status = %0d, expected %0d", $time,
               $sampled(error_status), HALTED_ON_HALT);
      end

    illegal_ok: assert property (@(posedge clock) disable iff (!arst_n)
        disp_valid[i] && disp_pc[i] == ILLEGAL_ADDR |-> stop_cycle &&
        error_status == HALTED_ON_ILLEGAL)
      else begin
        fail_count = fail_count + 1;
        $error("FAILED at %0t: error_status = %0d, expected %0d", $time,
               $sampled(error_status), HALTED_ON_ILLEGAL);
      end
  end

  pair_ok: assert property (@(posedge clock) disable iff (!arst_n)
      disp_valid[1] |-> disp_valid[0] && disp_pc[1] == disp_pc[0] + `XLEN'd4)
    else begin
      fail_count = fail_count + 1;
      $error("FAILED at %0t: disp_pc[1] = %h, expected %h", $time,
             $sampled(disp_pc[1]), $sampled(disp_pc[0]) + `XLEN'd4);
    end

  order_ok: assert property (@(posedge clock) disable iff (!arst_n)
      disp_valid[0] |-> disp_pc[0] == next_pc)
    else begin
      fail_count = fail_count + 1;
      $error("FAILED at %0t: disp_pc[0] = %h, expected %h", $time,
             $sampled(disp_pc[0]), $sampled(next_pc));
    end

  // A low ready level leaves the next cycle empty
  stall_ok: assert property (@(posedge clock) disable iff (!arst_n)
      !(rob_ready && rs_ready && fl_ready) |=> disp_valid == '0)
    else begin
      fail_count = fail_count + 1;
      $error("FAILED at %0t: disp_valid = %b after a ready gap, expected 00", $time,
             $sampled(disp_valid));
    end

  bus_cmd_ok: assert property (@(posedge clock) disable iff (!arst_n)
      dmem_command != BUS_NONE |-> proc2mem_command == dmem_command)
    else begin
      fail_count = fail_count + 1;
      $error("FAILED at %0t: proc2mem_command = %0d, expected %0d", $time,
             $sampled(proc2mem_command), $sampled(dmem_command));
    end

  bus_addr_ok: assert property (@(posedge clock) disable iff (!arst_n)
      dmem_command != BUS_NONE |-> proc2mem_addr == dmem_addr)
    else begin
      fail_count = fail_count + 1;
      $error("FAILED at %0t: proc2mem_addr = %h, expected %h", $time,
             $sampled(proc2mem_addr), $sampled(dmem_addr));
    end

  bus_data_ok: assert property (@(posedge clock) disable iff (!arst_n)
      dmem_command != BUS_NONE |-> proc2mem_data == dmem_data)
    else begin
      fail_count = fail_count + 1;
      $error("FAILED at %0t: proc2mem_data = %h, expected %h", $time,
             $sampled(proc2mem_data), $sampled(dmem_data));
    end

  bus_resp_ok: assert property (@(posedge clock) disable iff (!arst_n)
      dmem_command != BUS_NONE |-> dmem_response == mem2proc_response)
    else begin
      fail_count = fail_count + 1;
      $error("FAILED at %0t: dmem_response = %h, expected %h", $time,
             $sampled(dmem_response), $sampled(mem2proc_response));
    end

  // Nothing past a halt or illegal word
  after_stop_ok: assert property (@(posedge clock) disable iff (!arst_n)
      stop_cycle |=> disp_valid == '0)
    else begin
      fail_count = fail_count + 1;
      $error("FAILED at %0t: disp_valid = %b, expected 00", $time, $sampled(disp_valid));
    end

  slot1_stop_ok: assert property (@(posedge clock) disable iff (!arst_n)
      disp_valid[1] |-> disp_pc[0] != HALT_ADDR && disp_pc[0] != ILLEGAL_ADDR)
    else begin
      fail_count = fail_count + 1;
      $error("FAILED at %0t: slot 1 dispatched behind stop word at %h", $time,
             $sampled(disp_pc[0]));
    end

  count_ok: assert property (@(posedge clock) disable iff (!arst_n)
      completed_insts == 4'($countones(disp_valid)))
    else begin
      fail_count = fail_count + 1;
      $error("FAILED at %0t: completed_insts = %0d, expected %0d", $time,
             $sampled(completed_insts), $countones($sampled(disp_valid)));
    end

endmodule

bind frontend_top frontend_checker #(
  .HALT_ADDR    (64'h0000_0000_0001_0004),
  .ILLEGAL_ADDR (64'h0000_0000_0002_0000)
) checker_i (
  .clock             (clock),
  .arst_n            (arst_n),
  .rob_ready         (rob_ready),
  .rs_ready          (rs_ready),
  .fl_ready          (fl_ready),
  .rollback_en       (rollback_en),
  .rollback_pc       (rollback_pc),
  .dmem_command      (dmem_command),
  .dmem_addr         (dmem_addr),
  .dmem_data         (dmem_data),
  .mem2proc_response (mem2proc_response),
  .proc2mem_command  (proc2mem_command),
  .proc2mem_addr     (proc2mem_addr),
  .proc2mem_data     (proc2mem_data),
  .dmem_response     (dmem_response),
  .disp_valid        (disp_valid),
  .disp_pc           (disp_pc),
  .disp_inst         (disp_inst),
  .completed_insts   (completed_insts),
  .error_status      (error_status),
  .stop_cycle        (stop_cycle)
);

`default_nettype wire

/* source/frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defines.svh"

module frontend_top
  import bus_pkg::*;
  import inst_pkg::*;
(
  input  logic                                clock,
  input  logic                                arst_n,
  input  logic                                rob_ready,
  input  logic                                rs_ready,
  input  logic                                fl_ready,
  input  logic                                rollback_en,
  input  logic [`XLEN-1:0]                    rollback_pc,
  input  bus_cmd_t                            dmem_command,
  input  logic [`XLEN-1:0]                    dmem_addr,
  input  logic [`XLEN-1:0]                    dmem_data,
  input  mem_tag_t                            mem2proc_response,
  input  logic [`XLEN-1:0]                    mem2proc_data,
  input  mem_tag_t                            mem2proc_tag,
  output bus_cmd_t                            proc2mem_command,
  output logic [`XLEN-1:0]                    proc2mem_addr,
  output logic [`XLEN-1:0]                    proc2mem_data,
  output mem_tag_t                            dmem_response,
  output logic [`NUM_SUPER-1:0]               disp_valid,
  output logic [`NUM_SUPER-1:0][`XLEN-1:0]    disp_pc,
  output logic [`NUM_SUPER-1:0][`INST_W-1:0]  disp_inst,
  output logic [3:0]                          completed_insts,
  output error_code_t                         error_status,
  output logic                                stop_cycle
);

  logic [`NUM_SUPER-1:0]        wr_valid;
  inst_entry_t [`NUM_SUPER-1:0] wr_entry;
  logic                         fetch_room;
  logic [`NUM_SUPER-1:0]        head_valid;
  inst_entry_t [`NUM_SUPER-1:0] head_entry;
  logic [`NUM_SUPER-1:0]        pop;

  fetch_unit fetch_unit_i (
    .clock             (clock),
    .arst_n            (arst_n),
    .rollback_en       (rollback_en),
    .rollback_pc       (rollback_pc),
    .stop_cycle        (stop_cycle),
    .fetch_room        (fetch_room),
    .dmem_command      (dmem_command),
    .dmem_addr         (dmem_addr),
    .dmem_data         (dmem_data),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .dmem_response     (dmem_response),
    .wr_valid          (wr_valid),
    .wr_entry          (wr_entry)
  );

  fetch_buffer fetch_buffer_i (
    .clock      (clock),
    .arst_n     (arst_n),
    .flush      (rollback_en),  // whole queue goes on rollback
    .wr_valid   (wr_valid),
    .wr_entry   (wr_entry),
    .pop        (pop),
    .head_valid (head_valid),
    .head_entry (head_entry),
    .fetch_room (fetch_room)
  );

  dispatch_stage dispatch_stage_i (
    .clock           (clock),
    .arst_n          (arst_n),
    .rob_ready       (rob_ready),
    .rs_ready        (rs_ready),
    .fl_ready        (fl_ready),
    .rollback_en     (rollback_en),
    .head_valid      (head_valid),
    .head_entry      (head_entry),
    .pop             (pop),
    .disp_valid      (disp_valid),
    .disp_pc         (disp_pc),
    .disp_inst       (disp_inst),
    .completed_insts (completed_insts),
    .error_status    (error_status),
    .stop_cycle      (stop_cycle)
  );

endmodule

`default_nettype wire

/* source/dispatch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defines.svh"

module dispatch_stage
  import inst_pkg::*;
(
  input  logic                                  clock,
  input  logic                                  arst_n,
  input  logic                                  rob_ready,
  input  logic                                  rs_ready,
  input  logic                                  fl_ready,
  input  logic                                  rollback_en,
  input  logic [`NUM_SUPER-1:0]                 head_valid,
  input  inst_entry_t [`NUM_SUPER-1:0]          head_entry,
  output logic [`NUM_SUPER-1:0]                 pop,
  output logic [`NUM_SUPER-1:0]                 disp_valid,
  output logic [`NUM_SUPER-1:0][`XLEN-1:0]      disp_pc,
  output logic [`NUM_SUPER-1:0][`INST_W-1:0]    disp_inst,
  output logic [3:0]                            completed_insts,
  output error_code_t                           error_status,
  output logic                                  stop_cycle
);

  logic [`NUM_SUPER-1:0] is_halt;
  logic [`NUM_SUPER-1:0] is_illegal;
  logic [5:0]            opc [`NUM_SUPER];
  logic                  blocked;
  logic [3:0]            pop_cnt;
  error_code_t           nxt_err;

  always_comb begin
    for (int i = 0; i < `NUM_SUPER; i++) begin
      opc[i]        = head_entry[i].inst[31:26];
      is_halt[i]    = (head_entry[i].inst == `HALT_INST);
      is_illegal[i] = (opc[i] >= `ILLEGAL_OPC_LO) && (opc[i] <= `ILLEGAL_OPC_HI);
    end
  end

  // Slot 0 first, nothing past a halt or illegal word
  always_comb begin
    blocked = !(rob_ready && rs_ready && fl_ready) || rollback_en || stop_cycle;
    pop_cnt = '0;
    nxt_err = NO_ERROR;
    for (int i = 0; i < `NUM_SUPER; i++) begin
      pop[i] = head_valid[i] && !blocked;
      if (pop[i]) begin
        pop_cnt = pop_cnt + 4'd1;
        if (is_halt[i])
          nxt_err = HALTED_ON_HALT;
        else if (is_illegal[i])
          nxt_err = HALTED_ON_ILLEGAL;
      end
      if (!pop[i] || is_halt[i] || is_illegal[i])
        blocked = 1'b1;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      disp_valid      <= '0;
      completed_insts <= '0;
      error_status    <= NO_ERROR;
      stop_cycle      <= 1'b0;
    end else begin
      disp_valid      <= pop;
      completed_insts <= pop_cnt;
      if (nxt_err != NO_ERROR) begin  // sticky until reset
        error_status <= nxt_err;
        stop_cycle   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < `NUM_SUPER; i++) begin
      disp_pc[i]   <= head_entry[i].pc;
      disp_inst[i] <= head_entry[i].inst;
    end
  end

endmodule

`default_nettype wire

/* source/fetch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defines.svh"

module fetch_buffer
  import inst_pkg::*;
(
  input  logic                          clock,
  input  logic                          arst_n,
  input  logic                          flush,
  input  logic [`NUM_SUPER-1:0]         wr_valid,
  input  inst_entry_t [`NUM_SUPER-1:0]  wr_entry,
  input  logic [`NUM_SUPER-1:0]         pop,
  output logic [`NUM_SUPER-1:0]         head_valid,
  output inst_entry_t [`NUM_SUPER-1:0]  head_entry,
  output logic                          fetch_room
);

  localparam int PTR_W = $clog2(`FB_DEPTH);
  localparam int CNT_W = $clog2(`FB_DEPTH + 1);

  inst_entry_t             mem [`FB_DEPTH];
  logic [PTR_W-1:0]        head;
  logic [PTR_W-1:0]        tail;
  logic [CNT_W-1:0]        count;
  logic [CNT_W-1:0]        n_wr;
  logic [CNT_W-1:0]        n_pop;
  logic [`NUM_SUPER-1:0][PTR_W-1:0] wr_addr;

  // Valid slots are packed in order starting at tail
  always_comb begin
    n_wr = '0;
    for (int i = 0; i < `NUM_SUPER; i++) begin
      wr_addr[i] = tail + n_wr[PTR_W-1:0];
      n_wr       = n_wr + CNT_W'(wr_valid[i]);
    end
  end

  always_comb begin
    n_pop = '0;
    for (int i = 0; i < `NUM_SUPER; i++) begin
      n_pop = n_pop + CNT_W'(pop[i]);
    end
  end

  always_comb begin
    for (int i = 0; i < `NUM_SUPER; i++) begin
      head_valid[i] = (count > CNT_W'(i));
      head_entry[i] = mem[head + PTR_W'(i)];
    end
  end

  assign fetch_room = (CNT_W'(`FB_DEPTH) - count) >= CNT_W'(`NUM_SUPER);

  always_ff @(posedge clock) begin
    for (int i = 0; i < `NUM_SUPER; i++) begin
      if (wr_valid[i])
        mem[wr_addr[i]] <= wr_entry[i];
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin  // wins over same-cycle writes
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + n_pop[PTR_W-1:0];
      tail  <= tail + n_wr[PTR_W-1:0];
      count <= count + n_wr - n_pop;
    end
  end

endmodule

`default_nettype wire

/* fetch/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defines.svh"

module fetch_unit
  import bus_pkg::*;
  import inst_pkg::*;
(
  input  logic                          clock,
  input  logic                          arst_n,
  input  logic                          rollback_en,
  input  logic [`XLEN-1:0]              rollback_pc,
  input  logic                          stop_cycle,
  input  logic                          fetch_room,
  input  bus_cmd_t                      dmem_command,
  input  logic [`XLEN-1:0]              dmem_addr,
  input  logic [`XLEN-1:0]              dmem_data,
  input  mem_tag_t                      mem2proc_response,
  input  logic [`XLEN-1:0]              mem2proc_data,
  input  mem_tag_t                      mem2proc_tag,
  output bus_cmd_t                      proc2mem_command,
  output logic [`XLEN-1:0]              proc2mem_addr,
  output logic [`XLEN-1:0]              proc2mem_data,
  output mem_tag_t                      dmem_response,
  output logic [`NUM_SUPER-1:0]         wr_valid,
  output inst_entry_t [`NUM_SUPER-1:0]  wr_entry
);

  logic [`XLEN-1:0] fetch_pc;
  logic [`XLEN-1:0] line_pc;
  logic [`XLEN-1:0] next_line_pc;
  mem_tag_t         pend_tag;
  mem_tag_t         imem_response;
  logic             dmem_active;
  logic             busy;
  logic             fetch_req;
  logic             line_done;

  assign dmem_active = (dmem_command != BUS_NONE);
  assign busy        = (pend_tag != '0);

  // Data side owns the bus whenever it asks
  assign fetch_req = !busy && fetch_room && !dmem_active && !stop_cycle && !rollback_en;

  assign line_pc      = {fetch_pc[`XLEN-1:3], 3'b000};
  assign next_line_pc = line_pc + `XLEN'd8;

  assign proc2mem_command = dmem_active ? dmem_command :
                            fetch_req   ? BUS_LOAD     : BUS_NONE;
  assign proc2mem_addr    = dmem_active ? dmem_addr : line_pc;
  assign proc2mem_data    = dmem_active ? dmem_data : '0;

  assign dmem_response = dmem_active ? mem2proc_response : '0;
  assign imem_response = dmem_active ? '0 : mem2proc_response;

  // Late data after a rollback never matches, pend_tag is cleared
  assign line_done = busy && (mem2proc_tag == pend_tag) && !rollback_en;

  // Split the line, lower word first
  always_comb begin
    for (int i = 0; i < `NUM_SUPER; i++) begin
      wr_entry[i].pc   = line_pc + `XLEN'(4 * i);
      wr_entry[i].inst = mem2proc_data[i*`INST_W +: `INST_W];
      wr_valid[i]      = line_done && (i >= int'(fetch_pc[2]));
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      fetch_pc <= '0;
      pend_tag <= '0;
    end else if (rollback_en) begin
      fetch_pc <= rollback_pc;
      pend_tag <= '0;
    end else if (line_done) begin
      fetch_pc <= next_line_pc;
      pend_tag <= '0;
    end else if (fetch_req) begin
      pend_tag <= imem_response;  // 0 if refused, retried next cycle
    end
  end

endmodule

`default_nettype wire

/* common/inst_pkg.sv */
`default_nettype none

`include "frontend_defines.svh"

package inst_pkg;

  // One queued instruction, 96 bits
  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`INST_W-1:0] inst;
  } inst_entry_t;

  typedef enum logic [1:0] {
    NO_ERROR          = 2'h0,
    HALTED_ON_HALT    = 2'h1,
    HALTED_ON_ILLEGAL = 2'h2
  } error_code_t;

endpackage

`default_nettype wire

/* common/bus_pkg.sv */
`default_nettype none

`include "frontend_defines.svh"

package bus_pkg;

  typedef enum logic [`BUS_CMD_W-1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_t;

  // 0 = no transaction
  typedef logic [`MEM_TAG_W-1:0] mem_tag_t;

endpackage

`default_nettype wire

/* common/frontend_defines.svh */
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// Superscalar width, also the number of words per fetch line
`define NUM_SUPER 2

`define FB_DEPTH 8

`define XLEN 64
`define INST_W 32

// Memory bus field widths
`define BUS_CMD_W 2
`define MEM_TAG_W 4

// Alpha call_pal halt
`define HALT_INST 32'h0000_0555

// Reserved opcodes, instruction bits 31:26
`define ILLEGAL_OPC_LO 6'h01
`define ILLEGAL_OPC_HI 6'h07

`endif
